/* source/fp_format_pkg.sv */
package fp_format_pkg;

    // ========================================================================
    // FP32 field layout
    // ========================================================================

    localparam int EXP_W    = 8;
    localparam int MANT_W   = 23;
    localparam int EXP_BIAS = 127;
    // All-ones biased exponent, Inf and NaN
    localparam int EXP_MAX  = 255;

    // Quiet NaN returned for every NaN result
    localparam logic [31:0] QNAN_CANON = 32'h7fc0_0000;

    // ========================================================================
    // Datapath widths
    // ========================================================================

    // Exact 24 x 24 significand product
    localparam int PROD_W = 48;
    // Product in the low bits, addend above it, one spare carry bit on top
    localparam int SUM_W  = 76;

    typedef logic [31:0]           fp32_t;
    typedef logic [EXP_W-1:0]      exp_t;
    // Significand with hidden bit
    typedef logic [MANT_W:0]       sig_t;
    // Signed exponent, wide enough for overflow and underflow
    typedef logic signed [EXP_W+1:0] wide_exp_t;
    typedef logic [SUM_W-1:0]      sum_t;

endpackage

/* source/fma_ctrl_pkg.sv */
package fma_ctrl_pkg;

    // Rounding mode, frm field of the FP status register
    // Codes 5 to 7 fall back to round to nearest even
    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } rnd_mode_e;

    // Accrued flag positions in the 5-bit fflags word
    // Order is NV DZ OF UF NX from MSB down
    localparam int FLAG_NV_BIT = 4;
    localparam int FLAG_OF_BIT = 2;
    localparam int FLAG_NX_BIT = 0;

endpackage

/* source/operand_unpack.sv */
`timescale 1ns/1ps

module operand_unpack
    import fp_format_pkg::*;
    import fma_ctrl_pkg::*;
(
    input  fp32_t     a_i,
    input  fp32_t     b_i,
    input  fp32_t     c_i,
    input  rnd_mode_e rm_i,
    output logic      sign_a_o,
    output logic      sign_p_o,
    output logic      eff_sub_o,
    output exp_t      exp_a_o,
    output exp_t      exp_b_o,
    output exp_t      exp_c_o,
    output sig_t      sig_a_o,
    output sig_t      sig_b_o,
    output sig_t      sig_c_o,
    output logic      zero_a_o,
    output logic      zero_p_o,
    output logic      special_o,
    output fp32_t     special_result_o,
    output logic      special_nv_o
);

    // Operand order A, B, C
    fp32_t      op [3];
    logic [2:0] nan;
    logic [2:0] snan;
    logic [2:0] inf;
    logic [2:0] zero;
    logic       inf_p;
    logic       inv_mul;
    logic       inv_add;
    logic       zero_sign;

    assign op[0] = a_i;
    assign op[1] = b_i;
    assign op[2] = c_i;

    // Classify, subnormals count as zero
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            zero[i] = op[i][MANT_W +: EXP_W] == '0;
            inf[i]  = (op[i][MANT_W +: EXP_W] == exp_t'(EXP_MAX)) && (op[i][MANT_W-1:0] == '0);
            nan[i]  = (op[i][MANT_W +: EXP_W] == exp_t'(EXP_MAX)) && (op[i][MANT_W-1:0] != '0);
            // Quiet bit clear
            snan[i] = nan[i] & ~op[i][MANT_W-1];
        end
    end

    // Field split
    assign sign_a_o  = a_i[31];
    assign sign_p_o  = b_i[31] ^ c_i[31];
    // Effective subtraction by sign parity
    assign eff_sub_o = a_i[31] ^ b_i[31] ^ c_i[31];
    assign exp_a_o   = a_i[MANT_W +: EXP_W];
    assign exp_b_o   = b_i[MANT_W +: EXP_W];
    assign exp_c_o   = c_i[MANT_W +: EXP_W];
    assign sig_a_o   = zero[0] ? '0 : {1'b1, a_i[MANT_W-1:0]};
    assign sig_b_o   = zero[1] ? '0 : {1'b1, b_i[MANT_W-1:0]};
    assign sig_c_o   = zero[2] ? '0 : {1'b1, c_i[MANT_W-1:0]};
    assign zero_a_o  = zero[0];
    assign zero_p_o  = zero[1] | zero[2];

    // Invalid combinations
    assign inf_p   = inf[1] | inf[2];
    assign inv_mul = (inf[1] & zero[2]) | (zero[1] & inf[2]);
    assign inv_add = inf_p & inf[0] & eff_sub_o;

    // 0 - 0 gives -0 only when rounding down
    assign zero_sign = eff_sub_o ? (rm_i == RM_RDN) : a_i[31];

    // Fixed answers, NaN first, then infinities, then zero plus zero
    always_comb begin
        special_o        = 1'b1;
        special_nv_o     = 1'b0;
        special_result_o = QNAN_CANON;
        if ((|nan) | inv_mul | inv_add) begin
            special_nv_o = (|snan) | inv_mul | inv_add;
        end else if (inf_p) begin
            special_result_o = {sign_p_o, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
        end else if (inf[0]) begin
            special_result_o = {a_i[31], {EXP_W{1'b1}}, {MANT_W{1'b0}}};
        end else if (zero_p_o & zero[0]) begin
            special_result_o = {zero_sign, 31'b0};
        end else begin
            special_o = 1'b0;
        end
    end

endmodule

/* source/product_align.sv */
`timescale 1ns/1ps

module product_align
    import fp_format_pkg::*;
    import fma_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      valid_i,
    input  rnd_mode_e rm_i,
    input  logic      sign_a_i,
    input  logic      sign_p_i,
    input  logic      eff_sub_i,
    input  exp_t      exp_a_i,
    input  exp_t      exp_b_i,
    input  exp_t      exp_c_i,
    input  sig_t      sig_a_i,
    input  sig_t      sig_b_i,
    input  sig_t      sig_c_i,
    input  logic      zero_a_i,
    input  logic      zero_p_i,
    input  logic      special_i,
    input  fp32_t     special_result_i,
    input  logic      special_nv_i,
    output logic      valid_o,
    output sum_t      prod_o,
    output sum_t      addend_o,
    output logic      sticky_o,
    output wide_exp_t exp_ref_o,
    output logic      sign_a_o,
    output logic      sign_p_o,
    output logic      eff_sub_o,
    output rnd_mode_e rm_o,
    output logic      special_o,
    output fp32_t     special_result_o,
    output logic      special_nv_o
);

    // Addend LSB position with no shift puts the addend top at SUM_W-2
    localparam int ADD_LSB = SUM_W - MANT_W - 2;
    // Exponent gap at which the move amount is zero
    localparam int MV_OFS  = ADD_LSB - MANT_W;

    logic [PROD_W-1:0]  prod_raw;
    wide_exp_t          exp_p;
    wide_exp_t          mv;
    logic [6:0]         shamt;
    logic [2*SUM_W-1:0] shifted;
    sum_t               prod_d;
    sum_t               addend_d;
    logic               sticky_d;
    wide_exp_t          exp_ref_d;

    // ========================================================================
    // Product and exponent
    // ========================================================================

    assign prod_raw = sig_b_i * sig_c_i;
    assign exp_p    = wide_exp_t'(exp_b_i) + wide_exp_t'(exp_c_i) - wide_exp_t'(EXP_BIAS);
    // Right shift of the addend from its top slot
    assign mv       = exp_p + wide_exp_t'(MV_OFS) - wide_exp_t'(exp_a_i);
    assign shamt    = (mv > wide_exp_t'(SUM_W)) ? 7'(SUM_W) : mv[6:0];
    // Lower half collects bits pushed out below the product LSB
    assign shifted  = {1'b0, sig_a_i, {ADD_LSB{1'b0}}, {SUM_W{1'b0}}} >> shamt;

    // ========================================================================
    // Addend alignment
    // ========================================================================

    always_comb begin
        prod_d    = sum_t'(prod_raw);
        addend_d  = shifted[2*SUM_W-1:SUM_W];
        sticky_d  = |shifted[SUM_W-1:0];
        exp_ref_d = exp_p + wide_exp_t'(MV_OFS);
        if (zero_a_i) begin
            // Exact zero addend
            addend_d = '0;
            sticky_d = 1'b0;
        end else if (zero_p_i || mv < 0) begin
            // Addend far above so a nonzero product only tips the lowest bit
            prod_d    = sum_t'(!zero_p_i);
            addend_d  = {1'b0, sig_a_i, {ADD_LSB{1'b0}}};
            sticky_d  = 1'b0;
            exp_ref_d = wide_exp_t'(exp_a_i);
        end
    end

    // Stage 1 register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            prod_o           <= prod_d;
            addend_o         <= addend_d;
            sticky_o         <= sticky_d;
            exp_ref_o        <= exp_ref_d;
            sign_a_o         <= sign_a_i;
            sign_p_o         <= sign_p_i;
            eff_sub_o        <= eff_sub_i;
            rm_o             <= rm_i;
            special_o        <= special_i;
            special_result_o <= special_result_i;
            special_nv_o     <= special_nv_i;
        end
    end

endmodule

/* source/sum_normalize.sv */
`timescale 1ns/1ps

module sum_normalize
    import fp_format_pkg::*;
(
    input  sum_t      prod_i,
    input  sum_t      addend_i,
    input  logic      sticky_i,
    input  wide_exp_t exp_ref_i,
    input  logic      sign_a_i,
    input  logic      sign_p_i,
    input  logic      eff_sub_i,
    output sig_t      sig_o,
    output logic      guard_o,
    output logic      round_o,
    output logic      sticky_o,
    output wide_exp_t exp_o,
    output logic      sign_o,
    output logic      zero_o
);

    logic [SUM_W:0] raw;
    logic           borrow;
    logic           neg;
    sum_t           mag;
    sum_t           norm;
    logic [6:0]     lead;

    // ========================================================================
    // Wide add or subtract
    // ========================================================================

    // Lost addend bits borrow one LSB so the true value lies just above
    assign borrow = eff_sub_i & sticky_i;

    always_comb begin
        if (eff_sub_i) begin
            raw = {1'b0, prod_i} - {1'b0, addend_i} - (SUM_W+1)'(borrow);
        end else begin
            raw = {1'b0, prod_i} + {1'b0, addend_i};
        end
    end

    assign neg = raw[SUM_W];
    // Negative side needs one less when a borrow went in
    assign mag = neg ? (~raw[SUM_W-1:0] + sum_t'(!borrow)) : raw[SUM_W-1:0];
    // Addend larger than the product
    assign sign_o = neg ? sign_a_i : sign_p_i;
    assign zero_o = (mag == '0) & ~sticky_i;

    // ========================================================================
    // Leading one and normalizing shift
    // ========================================================================

    always_comb begin
        lead = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (mag[i]) begin
                lead = 7'(i);
            end
        end
    end

    assign norm = mag << (7'(SUM_W - 1) - lead);
    // Leading one at SUM_W-2 keeps the reference exponent
    assign exp_o = exp_ref_i + wide_exp_t'(lead) - wide_exp_t'(SUM_W - 2);

    // Significand and the bits below it
    assign sig_o    = norm[SUM_W-1 -: MANT_W+1];
    assign guard_o  = norm[SUM_W-MANT_W-2];
    assign round_o  = norm[SUM_W-MANT_W-3];
    assign sticky_o = (|norm[SUM_W-MANT_W-4:0]) | sticky_i;

endmodule

/* source/result_round.sv */
`timescale 1ns/1ps

module result_round
    import fp_format_pkg::*;
    import fma_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      valid_i,
    input  rnd_mode_e rm_i,
    input  logic      special_i,
    input  fp32_t     special_result_i,
    input  logic      special_nv_i,
    input  sig_t      sig_i,
    input  logic      guard_i,
    input  logic      round_i,
    input  logic      sticky_i,
    input  wide_exp_t exp_i,
    input  logic      sign_i,
    input  logic      zero_i,
    output logic      valid_o,
    output fp32_t     result_o,
    output logic      nv_o,
    output logic      of_o,
    output logic      nx_o
);

    logic              inexact;
    logic              inc;
    logic              to_inf;
    logic [MANT_W+1:0] rounded;
    logic [MANT_W-1:0] frac;
    wide_exp_t         exp_r;
    fp32_t             result_d;
    logic [4:0]        flags_d;
    logic [4:0]        flags_q;

    // ========================================================================
    // Rounding decision
    // ========================================================================

    assign inexact = guard_i | round_i | sticky_i;

    always_comb begin
        case (rm_i)
            RM_RTZ: begin
                inc    = 1'b0;
                to_inf = 1'b0;
            end
            RM_RDN: begin
                inc    = sign_i & inexact;
                to_inf = sign_i;
            end
            RM_RUP: begin
                inc    = ~sign_i & inexact;
                to_inf = ~sign_i;
            end
            // Ties away from zero
            RM_RMM: begin
                inc    = guard_i;
                to_inf = 1'b1;
            end
            default: begin
                inc    = guard_i & (round_i | sticky_i | sig_i[0]);
                to_inf = 1'b1;
            end
        endcase
    end

    // Carry out of the significand bumps the exponent
    assign rounded = {1'b0, sig_i} + (MANT_W+2)'(inc);
    assign frac    = rounded[MANT_W+1] ? rounded[MANT_W:1] : rounded[MANT_W-1:0];
    assign exp_r   = exp_i + wide_exp_t'(rounded[MANT_W+1]);

    // ========================================================================
    // Result select and flags
    // ========================================================================

    always_comb begin
        flags_d = '0;
        if (special_i) begin
            result_d             = special_result_i;
            flags_d[FLAG_NV_BIT] = special_nv_i;
        end else if (zero_i) begin
            // Exact cancellation
            result_d = {rm_i == RM_RDN, 31'b0};
        end else if (exp_r >= wide_exp_t'(EXP_MAX)) begin
            // Inf or largest finite
            result_d = to_inf ? {sign_i, exp_t'(EXP_MAX), {MANT_W{1'b0}}}
                              : {sign_i, exp_t'(EXP_MAX - 1), {MANT_W{1'b1}}};
            flags_d[FLAG_OF_BIT] = 1'b1;
            flags_d[FLAG_NX_BIT] = 1'b1;
        end else if (exp_r < wide_exp_t'(1)) begin
            // Flush below the normal range
            result_d             = {sign_i, 31'b0};
            flags_d[FLAG_NX_BIT] = 1'b1;
        end else begin
            result_d             = {sign_i, exp_r[EXP_W-1:0], frac};
            flags_d[FLAG_NX_BIT] = inexact;
        end
    end

    // Output register
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            flags_q <= '0;
        end else begin
            valid_o <= valid_i;
            flags_q <= valid_i ? flags_d : '0;
        end
    end

    always_ff @(posedge clk_i) begin
        result_o <= result_d;
    end

    assign nv_o = flags_q[FLAG_NV_BIT];
    assign of_o = flags_q[FLAG_OF_BIT];
    assign nx_o = flags_q[FLAG_NX_BIT];

endmodule

/* source/fma32_top.sv */
`timescale 1ns/1ps

module fma32_top
    import fp_format_pkg::*;
    import fma_ctrl_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      valid_i,
    input  rnd_mode_e rm_i,
    input  fp32_t     a_i,
    input  fp32_t     b_i,
    input  fp32_t     c_i,
    output logic      valid_o,
    output fp32_t     result_o,
    output logic      nv_o,
    output logic      of_o,
    output logic      nx_o
);

    // Unpack to align
    logic      u_sign_a, u_sign_p, u_eff_sub;
    exp_t      u_exp_a, u_exp_b, u_exp_c;
    sig_t      u_sig_a, u_sig_b, u_sig_c;
    logic      u_zero_a, u_zero_p;
    logic      u_special, u_special_nv;
    fp32_t     u_special_result;

    // Stage 1 register outputs
    logic      s1_valid, s1_sticky;
    sum_t      s1_prod, s1_addend;
    wide_exp_t s1_exp_ref;
    logic      s1_sign_a, s1_sign_p, s1_eff_sub;
    rnd_mode_e s1_rm;
    logic      s1_special, s1_special_nv;
    fp32_t     s1_special_result;

    // Normalize to round
    sig_t      n_sig;
    logic      n_guard, n_round, n_sticky;
    wide_exp_t n_exp;
    logic      n_sign, n_zero;

    operand_unpack i_unpack (
        .a_i(a_i), .b_i(b_i), .c_i(c_i), .rm_i(rm_i),
        .sign_a_o(u_sign_a), .sign_p_o(u_sign_p), .eff_sub_o(u_eff_sub),
        .exp_a_o(u_exp_a), .exp_b_o(u_exp_b), .exp_c_o(u_exp_c),
        .sig_a_o(u_sig_a), .sig_b_o(u_sig_b), .sig_c_o(u_sig_c),
        .zero_a_o(u_zero_a), .zero_p_o(u_zero_p),
        .special_o(u_special), .special_result_o(u_special_result),
        .special_nv_o(u_special_nv)
    );

    // ========================================================================
    // Stage 1, product and alignment
    // ========================================================================

    product_align i_align (
        .clk_i(clk_i), .reset_i(reset_i), .valid_i(valid_i), .rm_i(rm_i),
        .sign_a_i(u_sign_a), .sign_p_i(u_sign_p), .eff_sub_i(u_eff_sub),
        .exp_a_i(u_exp_a), .exp_b_i(u_exp_b), .exp_c_i(u_exp_c),
        .sig_a_i(u_sig_a), .sig_b_i(u_sig_b), .sig_c_i(u_sig_c),
        .zero_a_i(u_zero_a), .zero_p_i(u_zero_p),
        .special_i(u_special), .special_result_i(u_special_result),
        .special_nv_i(u_special_nv),
        .valid_o(s1_valid), .prod_o(s1_prod), .addend_o(s1_addend),
        .sticky_o(s1_sticky), .exp_ref_o(s1_exp_ref),
        .sign_a_o(s1_sign_a), .sign_p_o(s1_sign_p), .eff_sub_o(s1_eff_sub),
        .rm_o(s1_rm), .special_o(s1_special),
        .special_result_o(s1_special_result), .special_nv_o(s1_special_nv)
    );

    // ========================================================================
    // Stage 2, add, normalize, round
    // ========================================================================

    sum_normalize i_norm (
        .prod_i(s1_prod), .addend_i(s1_addend), .sticky_i(s1_sticky),
        .exp_ref_i(s1_exp_ref), .sign_a_i(s1_sign_a), .sign_p_i(s1_sign_p),
        .eff_sub_i(s1_eff_sub),
        .sig_o(n_sig), .guard_o(n_guard), .round_o(n_round), .sticky_o(n_sticky),
        .exp_o(n_exp), .sign_o(n_sign), .zero_o(n_zero)
    );

    result_round i_round (
        .clk_i(clk_i), .reset_i(reset_i), .valid_i(s1_valid), .rm_i(s1_rm),
        .special_i(s1_special), .special_result_i(s1_special_result),
        .special_nv_i(s1_special_nv),
        .sig_i(n_sig), .guard_i(n_guard), .round_i(n_round), .sticky_i(n_sticky),
        .exp_i(n_exp), .sign_i(n_sign), .zero_i(n_zero),
        .valid_o(valid_o), .result_o(result_o),
        .nv_o(nv_o), .of_o(of_o), .nx_o(nx_o)
    );

endmodule

/* dv/fma_clk_gen.sv */
`timescale 1ns/1ps

module fma_clk_gen (
    output logic clk_o,
    output logic reset_o
);

    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 4;

    // Free running 10 ns clock
    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

/* dv/fma32_tb.sv */
`timescale 1ns/1ps

module fma32_tb
    import fp_format_pkg::*;
    import fma_ctrl_pkg::*;
();

    localparam int CLK_PERIOD = 10;
    localparam int LATENCY = 2;
    localparam logic [31:0] SEED = 32'h895d_c85b;
    localparam int INT_OPS_PER_MODE = 8;
    localparam int N_OPS = 8 + 5 * INT_OPS_PER_MODE + 10 + 8 + 7 + 4;
    localparam int N_TESTS = 6;
    // One cycle per operation plus drain and idle cycles per test and reset
    localparam int WATCHDOG_CYCLES = N_OPS + 10 * N_TESTS + 20;
    localparam int DRAIN_LIMIT = 10;

    localparam fp32_t FP_ONE     = 32'h3f80_0000;
    localparam fp32_t FP_TWO     = 32'h4000_0000;
    localparam fp32_t FP_THREE   = 32'h4040_0000;
    localparam fp32_t FP_POS_INF = 32'h7f80_0000;
    localparam fp32_t FP_NEG_INF = 32'hff80_0000;

    // Flag vectors ordered NV, OF, NX
    localparam logic [2:0] FL_NONE = 3'b000;
    localparam logic [2:0] FL_NX   = 3'b001;
    localparam logic [2:0] FL_OFNX = 3'b011;
    localparam logic [2:0] FL_NV   = 3'b100;

    logic      clk;
    logic      reset;
    logic      op_valid;
    rnd_mode_e op_rm;
    fp32_t     op_a;
    fp32_t     op_b;
    fp32_t     op_c;
    logic      res_valid;
    fp32_t     result;
    logic      nv;
    logic      of;
    logic      nx;

    int          cycle_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    logic [31:0] rng_state = SEED;

    // Expected side filled at issue
    fp32_t      exp_res_q[$];
    logic [2:0] exp_flags_q[$];
    int         issue_cyc_q[$];
    string      tag_q[$];
    // Observed side filled by the monitor
    fp32_t      got_res_q[$];
    logic [2:0] got_flags_q[$];
    int         got_cyc_q[$];

    fma_clk_gen i_clk_gen (
        .clk_o(clk),
        .reset_o(reset)
    );

    fma32_top i_dut (
        .clk_i(clk), .reset_i(reset), .valid_i(op_valid), .rm_i(op_rm),
        .a_i(op_a), .b_i(op_b), .c_i(op_c),
        .valid_o(res_valid), .result_o(result),
        .nv_o(nv), .of_o(of), .nx_o(nx)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Outputs sampled mid-cycle away from the rising edge
    always @(negedge clk) begin
        if (res_valid === 1'b1) begin
            got_res_q.push_back(result);
            got_flags_q.push_back({nv, of, nx});
            got_cyc_q.push_back(cycle_cnt);
        end
    end

    // ========================================================================
    // Reference model helpers
    // ========================================================================

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Exact for magnitudes below 2^24
    function automatic fp32_t int_to_fp32(input logic neg, input int unsigned mag);
        int          pos;
        logic [31:0] aligned;
        if (mag == 0) begin
            return {neg, 31'b0};
        end
        pos = 0;
        for (int i = 0; i < 24; i++) begin
            if (mag[i]) begin
                pos = i;
            end
        end
        aligned = mag << (23 - pos);
        return {neg, 8'(EXP_BIAS + pos), aligned[MANT_W-1:0]};
    endfunction

    function automatic fp32_t expect_int_fma(input logic sa, input int unsigned a,
                                             input logic sb, input int unsigned b,
                                             input logic sc, input int unsigned c,
                                             input rnd_mode_e rm);
        int   prod;
        int   sum;
        logic sp;
        sp   = sb ^ sc;
        prod = int'(b * c);
        sum  = (sa ? -int'(a) : int'(a)) + (sp ? -prod : prod);
        if (sum > 0) begin
            return int_to_fp32(1'b0, sum);
        end
        if (sum < 0) begin
            return int_to_fp32(1'b1, -sum);
        end
        // Zero plus zero of equal sign keeps that sign
        if (a == 0 && prod == 0 && sa == sp) begin
            return {sa, 31'b0};
        end
        return {rm == RM_RDN, 31'b0};
    endfunction

    // 1 +/- 2^-30 sits just off 1.0 between two neighbours
    function automatic fp32_t tiny_addend_expect(input logic neg, input rnd_mode_e rm);
        case (rm)
            RM_RTZ, RM_RDN: return neg ? 32'h3f7f_ffff : FP_ONE;
            RM_RUP:         return neg ? FP_ONE : 32'h3f80_0001;
            default:        return FP_ONE;
        endcase
    endfunction

    // Inf when rounding toward the sign or to nearest
    function automatic fp32_t overflow_expect(input logic neg, input rnd_mode_e rm);
        logic to_inf;
        to_inf = (rm == RM_RUP) ? !neg :
                 (rm == RM_RDN) ? neg :
                 (rm == RM_RTZ) ? 1'b0 : 1'b1;
        return to_inf ? {neg, 8'hff, 23'h0} : {neg, 8'hfe, 23'h7f_ffff};
    endfunction

    // ========================================================================
    // Drive and check
    // ========================================================================

    task automatic issue_op(input fp32_t a, input fp32_t b, input fp32_t c,
                            input rnd_mode_e rm, input fp32_t exp_res,
                            input logic [2:0] exp_flags, input string tag);
        @(negedge clk);
        exp_res_q.push_back(exp_res);
        exp_flags_q.push_back(exp_flags);
        // Drive edge is the next one
        issue_cyc_q.push_back(cycle_cnt + 1);
        tag_q.push_back(tag);
        @(posedge clk);
        op_valid <= 1'b1;
        op_rm    <= rm;
        op_a     <= a;
        op_b     <= b;
        op_c     <= c;
    endtask

    task automatic check_word(input string what, input string tag,
                              input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("mismatch at %0t ns: %s %s got %h, expected %h", $time, tag, what,
                     got, exp);
        end
    endtask

    task automatic check_results(input string name, input int fails_at_start);
        int n;
        int waited;
        @(posedge clk);
        op_valid <= 1'b0;
        n = exp_res_q.size();
        waited = 0;
        while (got_res_q.size() < n && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (got_res_q.size() >= n) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("%s: only %0d of %0d results came back from the DUT", name,
                     got_res_q.size(), n);
        end
        // Late strobes show up here
        repeat (3) @(negedge clk);
        assert (got_res_q.size() <= n) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("%s: the DUT raised valid_o more often than operations were issued",
                     name);
        end
        // One result per operation in issue order
        while (exp_res_q.size() > 0 && got_res_q.size() > 0) begin
            check_word("result", tag_q[0], got_res_q.pop_front(), exp_res_q.pop_front());
            check_word("flags", tag_q[0], 32'(got_flags_q.pop_front()),
                       32'(exp_flags_q.pop_front()));
            check_word("latency", tag_q[0], got_cyc_q.pop_front() - issue_cyc_q[0],
                       LATENCY);
            void'(issue_cyc_q.pop_front());
            void'(tag_q.pop_front());
        end
        exp_res_q.delete();
        exp_flags_q.delete();
        issue_cyc_q.delete();
        tag_q.delete();
        got_res_q.delete();
        got_flags_q.delete();
        got_cyc_q.delete();
        $display("%-20s %0d ops, %0d errors", name, n, fail_cnt - fails_at_start);
    endtask

    // ========================================================================
    // Tests
    // ========================================================================

    task automatic back_to_back_latency();
        int fails_at_start;
        fails_at_start = fail_cnt;
        // Output side stays quiet through and after reset
        @(negedge clk);
        while (reset) begin
            check_word("valid and flags in reset", "reset", {res_valid, nv, of, nx}, 0);
            @(negedge clk);
        end
        check_word("valid and flags after reset", "reset", {res_valid, nv, of, nx}, 0);
        for (int k = 0; k < 8; k++) begin
            issue_op(int_to_fp32(1'b0, 3 * k), int_to_fp32(1'b0, k + 1),
                     int_to_fp32(1'b0, 5), rnd_mode_e'(k % 5),
                     expect_int_fma(1'b0, 3 * k, 1'b0, k + 1, 1'b0, 5, rnd_mode_e'(k % 5)),
                     FL_NONE, $sformatf("burst op %0d", k));
        end
        check_results("latency/throughput", fails_at_start);
    endtask

    task automatic exact_integer_sums();
        logic [31:0] r0;
        logic [31:0] r1;
        int unsigned a;
        int unsigned b;
        int unsigned c;
        logic        sa;
        logic        sb;
        logic        sc;
        rnd_mode_e   rm;
        int          fails_at_start;
        fails_at_start = fail_cnt;
        for (int m = 0; m < 5; m++) begin
            rm = rnd_mode_e'(m);
            for (int k = 0; k < INT_OPS_PER_MODE; k++) begin
                r0 = next_rand();
                r1 = next_rand();
                a  = r0[10:0];
                b  = r0[21:11];
                c  = r1[10:0];
                sa = r0[22];
                sb = r0[23];
                sc = r1[11];
                issue_op(int_to_fp32(sa, a), int_to_fp32(sb, b), int_to_fp32(sc, c), rm,
                         expect_int_fma(sa, a, sb, b, sc, c, rm), FL_NONE,
                         $sformatf("mode %0d op %0d", m, k));
            end
        end
        check_results("exact integers", fails_at_start);
    endtask

    task automatic tiny_addend_rounding();
        fp32_t a;
        int    fails_at_start;
        fails_at_start = fail_cnt;
        for (int s = 0; s < 2; s++) begin
            // +/- 2^-30
            a = s ? 32'hb080_0000 : 32'h3080_0000;
            for (int m = 0; m < 5; m++) begin
                issue_op(a, FP_ONE, FP_ONE, rnd_mode_e'(m),
                         tiny_addend_expect(s[0], rnd_mode_e'(m)), FL_NX,
                         $sformatf("sign %0d mode %0d", s, m));
            end
        end
        check_results("tiny addend", fails_at_start);
    endtask

    task automatic special_operands();
        int fails_at_start;
        fails_at_start = fail_cnt;
        issue_op(FP_ONE, FP_POS_INF, 32'h0, RM_RNE, QNAN_CANON, FL_NV, "inf x 0");
        issue_op(FP_NEG_INF, FP_POS_INF, FP_ONE, RM_RNE, QNAN_CANON, FL_NV, "inf - inf");
        issue_op(32'h7fc1_2345, FP_ONE, FP_ONE, RM_RNE, QNAN_CANON, FL_NONE, "quiet nan");
        issue_op(FP_ONE, FP_ONE, 32'h7f80_0001, RM_RNE, QNAN_CANON, FL_NV, "signalling nan");
        issue_op(FP_ONE, FP_NEG_INF, FP_TWO, RM_RNE, FP_NEG_INF, FL_NONE, "inf x finite");
        issue_op(32'h0, 32'h0, FP_THREE, RM_RNE, 32'h0, FL_NONE, "zero plus zero");
        // -6 + 2 x 3
        issue_op(32'hc0c0_0000, FP_TWO, FP_THREE, RM_RNE, 32'h0, FL_NONE, "cancel rne");
        issue_op(32'hc0c0_0000, FP_TWO, FP_THREE, RM_RDN, 32'h8000_0000, FL_NONE,
                 "cancel rdn");
        check_results("special cases", fails_at_start);
    endtask

    task automatic overflow_by_mode();
        int fails_at_start;
        fails_at_start = fail_cnt;
        // 2^100 x 2^100
        for (int m = 0; m < 5; m++) begin
            issue_op(FP_ONE, 32'h7180_0000, 32'h7180_0000, rnd_mode_e'(m),
                     overflow_expect(1'b0, rnd_mode_e'(m)), FL_OFNX,
                     $sformatf("positive mode %0d", m));
        end
        issue_op(FP_ONE, 32'hf180_0000, 32'h7180_0000, RM_RDN,
                 overflow_expect(1'b1, RM_RDN), FL_OFNX, "negative rdn");
        issue_op(FP_ONE, 32'hf180_0000, 32'h7180_0000, RM_RUP,
                 overflow_expect(1'b1, RM_RUP), FL_OFNX, "negative rup");
        check_results("overflow", fails_at_start);
    endtask

    task automatic flush_tiny_results();
        int fails_at_start;
        fails_at_start = fail_cnt;
        // 2^-70 squared is far below the normal range
        issue_op(32'h0, 32'h1c80_0000, 32'h1c80_0000, RM_RNE, 32'h0, FL_NX, "flush pos");
        issue_op(32'h0, 32'h9c80_0000, 32'h1c80_0000, RM_RNE, 32'h8000_0000, FL_NX,
                 "flush neg");
        issue_op(FP_ONE, 32'h0000_0001, FP_ONE, RM_RNE, FP_ONE, FL_NONE, "subnormal b");
        issue_op(32'h0040_0000, FP_ONE, FP_ONE, RM_RUP, FP_ONE, FL_NONE, "subnormal a");
        check_results("flush", fails_at_start);
    endtask

    // ========================================================================
    // Sequence and watchdog
    // ========================================================================

    initial begin
        op_valid <= 1'b0;
        op_rm    <= RM_RNE;
        op_a     <= '0;
        op_b     <= '0;
        op_c     <= '0;
        back_to_back_latency();
        exact_integer_sums();
        tiny_addend_rounding();
        special_operands();
        overflow_by_mode();
        flush_tiny_results();
        $display("summary: %0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d clock cycles",
                 WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* sources.f */
source/fp_format_pkg.sv
source/fma_ctrl_pkg.sv
source/operand_unpack.sv
source/product_align.sv
source/sum_normalize.sv
source/result_round.sv
source/fma32_top.sv
dv/fma_clk_gen.sv
dv/fma32_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the FMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -Wno-fatal --top-module fma32_tb \
    -f sources.f -Mdir "$BUILD"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD/Vfma32_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# Verdict comes from the log
if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
exit 0
